// File: cmd_decode.sv
// Command decode stage of the timer unit
// Checks each strobed command and turns it into per-channel controls
// Purely combinational: the controls act at the edge that samples the command
`timescale 1ns/1ns

module cmd_decode import decr_timer_pkg::*; (
  input  logic                   cmd_valid,
  input  timer_op_e              cmd_op,
  input  logic                   cmd_chan,
  input  logic [  ARG_WIDTH-1:0] cmd_arg,
  output logic                   set_init0,
  output logic                   set_init1,
  output logic                   reinit0,
  output logic                   reinit1,
  output logic                   decr_valid0,
  output logic                   decr_valid1,
  output logic [ DECR_WIDTH-1:0] decr,
  output logic [VALUE_WIDTH-1:0] init_data,
  output logic                   cmd_reject
);

  logic [ARG_WIDTH-1:0] chan_max;
  logic                 decr_too_big;
  logic                 init_too_big;
  logic                 set_init;
  logic                 reinit;
  logic                 decr_valid;

  // Limit of whichever channel the command addresses
  assign chan_max = cmd_chan ? ARG_WIDTH'(CH1_MAX) : ARG_WIDTH'(CH0_MAX);

  // Range checks, applied below only to the opcodes they concern
  assign decr_too_big = cmd_arg > ARG_WIDTH'(MAX_DECR);
  assign init_too_big = cmd_arg > chan_max;

  // ----------------------------------------------------------
  // Opcode decode
  // ----------------------------------------------------------

  // A failing check raises only the reject, so nothing else moves
  always_comb begin
    set_init   = 1'b0;
    reinit     = 1'b0;
    decr_valid = 1'b0;
    cmd_reject = 1'b0;
    if (cmd_valid) begin
      case (cmd_op)
        OP_SET_INIT: begin
          cmd_reject = init_too_big;
          set_init   = !init_too_big;
        end
        OP_REINIT: begin
          reinit = 1'b1;
        end
        OP_DECR: begin
          cmd_reject = decr_too_big;
          decr_valid = !decr_too_big;
        end
        OP_REINIT_DECR: begin
          cmd_reject = decr_too_big;
          reinit     = !decr_too_big;
          decr_valid = !decr_too_big;
        end
        default: begin
          cmd_reject = 1'b1;
        end
      endcase
    end
  end

  // Steer the controls to the addressed channel
  assign set_init0   = set_init && !cmd_chan;
  assign set_init1   = set_init && cmd_chan;
  assign reinit0     = reinit && !cmd_chan;
  assign reinit1     = reinit && cmd_chan;
  assign decr_valid0 = decr_valid && !cmd_chan;
  assign decr_valid1 = decr_valid && cmd_chan;

  // Both channels share the data fields, the strobes pick the target
  assign decr      = cmd_arg[DECR_WIDTH-1:0];
  assign init_data = VALUE_WIDTH'(cmd_arg);

endmodule

// File: counter_decr.sv
// Decrementing counter with reinit, as used for credit and retry timers
// On underflow it either wraps into 0..max_value or clamps at zero,
// chosen by the saturate parameter
// value_next shows the count for the next cycle, underflow flags a wrap or clamp
`timescale 1ns/1ns

module counter_decr import decr_timer_pkg::*; #(
  parameter int max_value     = CH0_MAX,
  parameter int max_decrement = MAX_DECR,
  parameter bit saturate      = 1'b0
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   reinit,
  input  logic [VALUE_WIDTH-1:0] initial_value,
  input  logic                   decr_valid,
  input  logic [ DECR_WIDTH-1:0] decr,
  output logic [VALUE_WIDTH-1:0] value,
  output logic [VALUE_WIDTH-1:0] value_next,
  output logic                   underflow
);

  logic [VALUE_WIDTH-1:0] base_value;
  logic [ DECR_WIDTH-1:0] decr_limited;
  logic [VALUE_WIDTH-1:0] decr_ext;
  logic [VALUE_WIDTH-1:0] value_temp;

  // ----------------------------------------------------------
  // Next-value arithmetic
  // ----------------------------------------------------------

  // A reinit replaces the current count, so a decrement in the same
  // cycle is taken off the initial value instead
  assign base_value = reinit ? initial_value : value;

  // Requests above the channel's decrement limit are held to the limit
  assign decr_limited = (decr > DECR_WIDTH'(max_decrement)) ?
                        DECR_WIDTH'(max_decrement) : decr;

  // Without a valid decrement the subtraction is by zero
  assign decr_ext = decr_valid ? VALUE_WIDTH'(decr_limited) : '0;

  // Raw difference; on underflow it has wrapped modulo 2**VALUE_WIDTH
  assign value_temp = base_value - decr_ext;

  // Underflow means the decrement went past zero, landing on zero is not one
  assign underflow = decr_valid && (decr_ext > base_value);

  // ----------------------------------------------------------
  // Underflow handling
  // ----------------------------------------------------------

  if (saturate) begin : gen_saturate
    // Clamp at zero once the count runs out
    assign value_next = underflow ? '0 : value_temp;
  end else begin : gen_wrap
    logic [VALUE_WIDTH-1:0] wrap_margin;
    logic [VALUE_WIDTH-1:0] value_wrapped;

    // Codes above max_value are unused; after an underflow the raw result
    // sits that many codes too high, so pulling it down by the margin
    // gives the result modulo max_value + 1
    // For a power-of-two range the margin is zero and this folds away
    assign wrap_margin   = VALUE_WIDTH'((2 ** VALUE_WIDTH) - 1 - max_value);
    assign value_wrapped = value_temp - wrap_margin;
    assign value_next    = underflow ? value_wrapped : value_temp;
  end

  // ----------------------------------------------------------
  // Count register
  // ----------------------------------------------------------

  // Only a decrement or a reinit moves the count; reset starts it at the top
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      value <= VALUE_WIDTH'(max_value);
    end else if (decr_valid || reinit) begin
      value <= value_next;
    end
  end

endmodule

// File: decr_timer.f
decr_timer_pkg.sv
counter_decr.sv
cmd_decode.sv
timer_execute.sv
result_flags.sv
decr_timer_top.sv
decr_timer_assertions.sv
decr_timer_tb.sv

// File: decr_timer_assertions.sv
// Concurrent checks on the timer's internal and output signals
// Bound to the top level, so the RTL itself carries no checking code
`timescale 1ns/1ns

module decr_timer_assertions import decr_timer_pkg::*; (
  input logic                   clk,
  input logic                   arst_n,
  input logic [VALUE_WIDTH-1:0] value0,
  input logic [VALUE_WIDTH-1:0] value1,
  input logic [VALUE_WIDTH-1:0] value1_next,
  input logic                   underflow0,
  input logic                   cmd_reject,
  input logic                   wrap0,
  input logic                   cmd_error
);

  // ----------------------------------------------------------
  // Range and pulse-source checks
  // ----------------------------------------------------------

  // Counts stay inside their channel range
  assert property (@(posedge clk) disable iff (!arst_n) value0 <= CH0_MAX)
    else $error("value0 is above the channel 0 maximum");
  assert property (@(posedge clk) disable iff (!arst_n) value1 <= CH1_MAX)
    else $error("value1 is above the channel 1 maximum");

  // A wrap follows an underflow and lands within one decrement of the top
  assert property (@(posedge clk) disable iff (!arst_n)
                   wrap0 |-> $past(underflow0) && (value0 > CH0_MAX - MAX_DECR))
    else $error("wrap0 pulsed without an underflow or off the top of the range");

  // A rejected command leaves both counts where they were
  assert property (@(posedge clk) disable iff (!arst_n)
                   cmd_error |-> $past(cmd_reject) && $stable(value0) && $stable(value1))
    else $error("cmd_error pulsed without a reject or a count moved");

  // The registered count always follows the previewed next value
  assert property (@(posedge clk) disable iff (!arst_n) value1 == $past(value1_next))
    else $error("value1 differs from the previous value1_next");

endmodule

bind decr_timer_top decr_timer_assertions u_assertions (
  .clk        (clk),
  .arst_n     (arst_n),
  .value0     (value0),
  .value1     (value1),
  .value1_next(value1_next),
  .underflow0 (underflow0),
  .cmd_reject (cmd_reject),
  .wrap0      (wrap0),
  .cmd_error  (cmd_error)
);

// File: decr_timer_pkg.sv
// Shared definitions for the two-channel countdown timer
// Holds the command opcodes, the datapath widths and the per-channel limits
// Imported by every RTL module and by the testbench
package decr_timer_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------

  // Width of the argument carried by each command
  localparam int ARG_WIDTH = 8;

  // Counter value width, wide enough to hold the largest channel maximum
  localparam int VALUE_WIDTH = 8;

  // Width of the decrement fed to a counter
  localparam int DECR_WIDTH = 4;

  // ----------------------------------------------------------
  // Limits
  // ----------------------------------------------------------

  // Largest decrement a command may request
  localparam int MAX_DECR = 15;

  // Channel 0 counts modulo 100, so it wraps from 0 back up to 99
  localparam int CH0_MAX = 99;

  // Channel 1 stops at zero instead of wrapping
  localparam int CH1_MAX = 200;

  // Number of timer channels in the unit
  localparam int NUM_CHAN = 2;

  // ----------------------------------------------------------
  // Command opcodes
  // ----------------------------------------------------------

  // OP_SET_INIT writes the initial value of the selected channel
  // OP_REINIT reloads the counter from that initial value
  // OP_DECR subtracts the argument from the current count
  // OP_REINIT_DECR reloads and subtracts from the initial value in one step
  typedef enum logic [1:0] {
    OP_SET_INIT    = 2'd0,
    OP_REINIT      = 2'd1,
    OP_DECR        = 2'd2,
    OP_REINIT_DECR = 2'd3
  } timer_op_e;

endpackage

// File: decr_timer_tb.sv
// Directed testbench for the two-channel countdown timer
// Sends commands one per cycle and checks values and pulses against a model
// kept here from the timer's decode, counter and pulse rules
`timescale 1ns/1ns

module decr_timer_tb import decr_timer_pkg::*; ();

  // Generous bound on the cycles all tests take; the run stops at four times that
  localparam int TEST_BUDGET    = 500;
  localparam int TIMEOUT_CYCLES = 4 * TEST_BUDGET;

  logic                   clk;
  logic                   arst_n;
  logic                   cmd_valid;
  timer_op_e              cmd_op;
  logic                   cmd_chan;
  logic [  ARG_WIDTH-1:0] cmd_arg;
  logic [VALUE_WIDTH-1:0] value0;
  logic [VALUE_WIDTH-1:0] value1;
  logic                   wrap0;
  logic                   expire1;
  logic                   cmd_error;

  // Model state: initial values and counter values per channel
  int     model_init [NUM_CHAN];
  int     model_val  [NUM_CHAN];
  int     error_count;
  int     errors_at_start;
  int     tests_passed;
  int     tests_failed;
  int     cycle_count;
  integer seed;

  decr_timer_top dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .cmd_valid(cmd_valid),
    .cmd_op   (cmd_op),
    .cmd_chan (cmd_chan),
    .cmd_arg  (cmd_arg),
    .value0   (value0),
    .value1   (value1),
    .wrap0    (wrap0),
    .expire1  (expire1),
    .cmd_error(cmd_error)
  );

  // 8 ns clock period
  always #4 clk = ~clk;

  // Stop a hung run once the cycle limit is reached
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------

  task automatic check_value(input string name, input logic [VALUE_WIDTH-1:0] expected,
                             input logic [VALUE_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_pulse(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %b actual %b", name, expected, actual);
      error_count++;
    end
  endtask

  function automatic int chan_limit(input logic chan);
    return chan ? CH1_MAX : CH0_MAX;
  endfunction

  // ----------------------------------------------------------
  // Command driver with model update and check
  // ----------------------------------------------------------

  // Called 1 ns after a rising edge; the command is taken at the next edge
  // and its result, pulses included, is checked 1 ns after that edge
  task automatic send_cmd(input string name, input timer_op_e op, input logic chan,
                          input logic [ARG_WIDTH-1:0] arg);
    int   next_val [NUM_CHAN];
    int   base;
    logic exp_wrap;
    logic exp_expire;
    logic exp_error;
    next_val   = model_val;
    exp_wrap   = 1'b0;
    exp_error  = 1'b0;
    case (op)
      OP_SET_INIT: begin
        if (arg > chan_limit(chan)) exp_error = 1'b1;
        else model_init[chan] = arg;
      end
      OP_REINIT: next_val[chan] = model_init[chan];
      default: begin
        if (arg > MAX_DECR) begin
          exp_error = 1'b1;
        end else begin
          // A reinit in the same cycle means the decrement hits the initial value
          base = (op == OP_REINIT_DECR) ? model_init[chan] : model_val[chan];
          if (arg <= base) begin
            next_val[chan] = base - arg;
          end else if (!chan) begin
            next_val[chan] = base + CH0_MAX + 1 - arg;
            exp_wrap       = 1'b1;
          end else begin
            next_val[chan] = 0;
          end
        end
      end
    endcase
    exp_expire = (next_val[1] == 0) && (model_val[1] != 0);
    model_val  = next_val;
    cmd_valid  = 1'b1;
    cmd_op     = op;
    cmd_chan   = chan;
    cmd_arg    = arg;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    check_value({name, " value0"}, VALUE_WIDTH'(model_val[0]), value0);
    check_value({name, " value1"}, VALUE_WIDTH'(model_val[1]), value1);
    check_pulse({name, " wrap0"}, exp_wrap, wrap0);
    check_pulse({name, " expire1"}, exp_expire, expire1);
    check_pulse({name, " cmd_error"}, exp_error, cmd_error);
  endtask

  task automatic start_test();
    errors_at_start = error_count;
  endtask

  task automatic finish_test(input string name);
    if (error_count == errors_at_start) begin
      $display("%s: passed", name);
      tests_passed++;
    end else begin
      $display("%s: failed with %0d mismatches", name, error_count - errors_at_start);
      tests_failed++;
    end
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------

  task automatic test_reset();
    start_test();
    check_value("reset value0", VALUE_WIDTH'(CH0_MAX), value0);
    check_value("reset value1", VALUE_WIDTH'(CH1_MAX), value1);
    check_pulse("reset wrap0", 1'b0, wrap0);
    check_pulse("reset expire1", 1'b0, expire1);
    check_pulse("reset cmd_error", 1'b0, cmd_error);
    finish_test("test_reset");
  endtask

  // Bring channel 0 down to 1, then step 3 past zero to land on 98
  task automatic test_wrap();
    start_test();
    send_cmd("wrap set_init", OP_SET_INIT, 1'b0, 8'd1);
    send_cmd("wrap reinit", OP_REINIT, 1'b0, 8'd0);
    send_cmd("wrap decr", OP_DECR, 1'b0, 8'd3);
    send_cmd("wrap after", OP_DECR, 1'b0, 8'd5);
    finish_test("test_wrap");
  endtask

  task automatic test_saturate();
    start_test();
    send_cmd("sat set_init", OP_SET_INIT, 1'b1, 8'd5);
    send_cmd("sat reinit", OP_REINIT, 1'b1, 8'd0);
    send_cmd("sat decr 3", OP_DECR, 1'b1, 8'd3);
    send_cmd("sat decr 4", OP_DECR, 1'b1, 8'd4);
    // Already parked at zero, so no second expiry
    send_cmd("sat decr again", OP_DECR, 1'b1, 8'd2);
    finish_test("test_saturate");
  endtask

  task automatic test_reinit();
    start_test();
    send_cmd("reinit set0", OP_SET_INIT, 1'b0, 8'd50);
    send_cmd("reinit ch0", OP_REINIT, 1'b0, 8'd0);
    send_cmd("reinit_decr ch0", OP_REINIT_DECR, 1'b0, 8'd7);
    send_cmd("reinit set1", OP_SET_INIT, 1'b1, 8'd120);
    send_cmd("reinit_decr ch1", OP_REINIT_DECR, 1'b1, 8'd15);
    finish_test("test_reinit");
  endtask

  task automatic test_reject();
    start_test();
    send_cmd("reject decr", OP_DECR, 1'b0, 8'd16);
    // Low bits nonzero, so a decrement that slipped through would move the count
    send_cmd("reject decr big", OP_DECR, 1'b0, 8'd23);
    send_cmd("reject reinit_decr", OP_REINIT_DECR, 1'b1, 8'd200);
    send_cmd("reject set0", OP_SET_INIT, 1'b0, 8'd100);
    send_cmd("reject set1", OP_SET_INIT, 1'b1, 8'd201);
    // Reloading shows the initial values were left alone
    send_cmd("reject reinit0", OP_REINIT, 1'b0, 8'd0);
    send_cmd("reject reinit1", OP_REINIT, 1'b1, 8'd0);
    finish_test("test_reject");
  endtask

  task automatic test_random();
    int                   r;
    int                   i;
    timer_op_e            op;
    logic                 chan;
    logic [ARG_WIDTH-1:0] arg;
    start_test();
    for (i = 0; i < 40; i++) begin
      r    = $random(seed);
      op   = timer_op_e'(r[1:0]);
      chan = r[2];
      if (op == OP_SET_INIT) arg = {$random(seed)} % (chan_limit(chan) + 1);
      else arg = {$random(seed)} % (MAX_DECR + 1);
      send_cmd($sformatf("random %0d", i), op, chan, arg);
    end
    finish_test("test_random");
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin
    clk             = 1'b0;
    arst_n          = 1'b0;
    cmd_valid       = 1'b0;
    cmd_op          = OP_SET_INIT;
    cmd_chan        = 1'b0;
    cmd_arg         = '0;
    seed            = 68206;
    error_count     = 0;
    errors_at_start = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    cycle_count     = 0;
    model_init[0]   = CH0_MAX;
    model_init[1]   = CH1_MAX;
    model_val[0]    = CH0_MAX;
    model_val[1]    = CH1_MAX;
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;
    test_reset();
    test_wrap();
    test_saturate();
    test_reinit();
    test_reject();
    test_random();
    $display("Tests passed: %0d, tests failed: %0d, mismatches: %0d",
             tests_passed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: decr_timer_top.sv
// Top level of the two-channel countdown timer
// Commands arrive as one-cycle strobes with no back-pressure;
// decode feeds execute, and result turns the outcome into pulses
`timescale 1ns/1ns

module decr_timer_top import decr_timer_pkg::*; (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   cmd_valid,
  input  timer_op_e              cmd_op,
  input  logic                   cmd_chan,
  input  logic [  ARG_WIDTH-1:0] cmd_arg,
  output logic [VALUE_WIDTH-1:0] value0,
  output logic [VALUE_WIDTH-1:0] value1,
  output logic                   wrap0,
  output logic                   expire1,
  output logic                   cmd_error
);

  // Decode to execute
  logic                   set_init0;
  logic                   set_init1;
  logic                   reinit0;
  logic                   reinit1;
  logic                   decr_valid0;
  logic                   decr_valid1;
  logic [ DECR_WIDTH-1:0] decr;
  logic [VALUE_WIDTH-1:0] init_data;

  // Into the result stage
  logic                   cmd_reject;
  logic [VALUE_WIDTH-1:0] value1_next;
  logic                   underflow0;

  cmd_decode u_decode (
    .cmd_valid  (cmd_valid),
    .cmd_op     (cmd_op),
    .cmd_chan   (cmd_chan),
    .cmd_arg    (cmd_arg),
    .set_init0  (set_init0),
    .set_init1  (set_init1),
    .reinit0    (reinit0),
    .reinit1    (reinit1),
    .decr_valid0(decr_valid0),
    .decr_valid1(decr_valid1),
    .decr       (decr),
    .init_data  (init_data),
    .cmd_reject (cmd_reject)
  );

  timer_execute u_execute (
    .clk        (clk),
    .arst_n     (arst_n),
    .set_init0  (set_init0),
    .set_init1  (set_init1),
    .reinit0    (reinit0),
    .reinit1    (reinit1),
    .decr_valid0(decr_valid0),
    .decr_valid1(decr_valid1),
    .decr       (decr),
    .init_data  (init_data),
    .value0     (value0),
    .value1     (value1),
    .value1_next(value1_next),
    .underflow0 (underflow0)
  );

  result_flags u_result (
    .clk        (clk),
    .arst_n     (arst_n),
    .underflow0 (underflow0),
    .value1     (value1),
    .value1_next(value1_next),
    .cmd_reject (cmd_reject),
    .wrap0      (wrap0),
    .expire1    (expire1),
    .cmd_error  (cmd_error)
  );

endmodule

// File: result_flags.sv
// Result stage of the timer unit
// Turns counter and decode events into one-cycle registered pulses
// Each pulse is set by the same edge that applies the command behind it
`timescale 1ns/1ns

module result_flags import decr_timer_pkg::*; (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   underflow0,
  input  logic [VALUE_WIDTH-1:0] value1,
  input  logic [VALUE_WIDTH-1:0] value1_next,
  input  logic                   cmd_reject,
  output logic                   wrap0,
  output logic                   expire1,
  output logic                   cmd_error
);

  logic reaches_zero1;

  // ----------------------------------------------------------
  // Event detection
  // ----------------------------------------------------------

  // Channel 1 expires only on the step from nonzero to zero,
  // a further decrement while parked at zero is not a new expiry
  assign reaches_zero1 = (value1_next == '0) && (value1 != '0);

  // ----------------------------------------------------------
  // Pulse registers
  // ----------------------------------------------------------

  // The sources are single-cycle events themselves, so a plain
  // register gives a pulse exactly one cycle wide
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wrap0     <= 1'b0;
      expire1   <= 1'b0;
      cmd_error <= 1'b0;
    end else begin
      // Channel 0 wrapped past zero this cycle
      wrap0     <= underflow0;
      expire1   <= reaches_zero1;
      // Decode threw the command away
      cmd_error <= cmd_reject;
    end
  end

endmodule

// File: timer_execute.sv
// Execute stage of the timer unit
// Keeps each channel's initial value and runs the two counters from it
// Channel 0 wraps modulo CH0_MAX + 1, channel 1 saturates at zero
`timescale 1ns/1ns

module timer_execute import decr_timer_pkg::*; (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   set_init0,
  input  logic                   set_init1,
  input  logic                   reinit0,
  input  logic                   reinit1,
  input  logic                   decr_valid0,
  input  logic                   decr_valid1,
  input  logic [ DECR_WIDTH-1:0] decr,
  input  logic [VALUE_WIDTH-1:0] init_data,
  output logic [VALUE_WIDTH-1:0] value0,
  output logic [VALUE_WIDTH-1:0] value1,
  output logic [VALUE_WIDTH-1:0] value1_next,
  output logic                   underflow0
);

  // One initial value per channel
  logic [VALUE_WIDTH-1:0] init_value [NUM_CHAN];

  // ----------------------------------------------------------
  // Initial-value registers
  // ----------------------------------------------------------

  // Reset matches the counters' own reset, so a reinit straight
  // after reset reloads the channel maximum
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      init_value[0] <= VALUE_WIDTH'(CH0_MAX);
      init_value[1] <= VALUE_WIDTH'(CH1_MAX);
    end else begin
      if (set_init0) init_value[0] <= init_data;
      if (set_init1) init_value[1] <= init_data;
    end
  end

  // ----------------------------------------------------------
  // Counters
  // ----------------------------------------------------------

  // Channel 0: 0..99, wraps on underflow; its value_next has no user here
  counter_decr #(
    .max_value    (CH0_MAX),
    .max_decrement(MAX_DECR),
    .saturate     (1'b0)
  ) chan0_counter (
    .clk          (clk),
    .arst_n       (arst_n),
    .reinit       (reinit0),
    .initial_value(init_value[0]),
    .decr_valid   (decr_valid0),
    .decr         (decr),
    .value        (value0),
    .value_next   (),
    .underflow    (underflow0)
  );

  // Channel 1: 0..200, holds at zero; expiry is found from value_next
  counter_decr #(
    .max_value    (CH1_MAX),
    .max_decrement(MAX_DECR),
    .saturate     (1'b1)
  ) chan1_counter (
    .clk          (clk),
    .arst_n       (arst_n),
    .reinit       (reinit1),
    .initial_value(init_value[1]),
    .decr_valid   (decr_valid1),
    .decr         (decr),
    .value        (value1),
    .value_next   (value1_next),
    .underflow    ()
  );

endmodule
